/* source/dl_re_pkg.sv */
package dl_re_pkg;

    // ----------------------------------------------------------------------
    // grid dimensions for one carrier
    // ----------------------------------------------------------------------

    // resource elements per PRB
    localparam int unsigned RE_PER_PRB   = 12;
    // one full pass over the carrier
    localparam int unsigned PRB_PER_SYM  = 132;
    // normal cyclic prefix
    localparam int unsigned SYM_PER_SLOT = 14;
    // packet length in PRBs, 48 words
    localparam int unsigned PRB_PER_PKT  = 4;

    // ----------------------------------------------------------------------
    // word layout
    // ----------------------------------------------------------------------

    // antennas carried side by side in one word
    localparam int unsigned LANE_NUM     = 4;
    // 16-bit I plus 16-bit Q
    localparam int unsigned IQ_W         = 32;

    typedef logic [IQ_W-1:0]          iq_sample_t;
    // lane k sits at bits 32k upward
    typedef logic [LANE_NUM*IQ_W-1:0] re_word_t;

    // ----------------------------------------------------------------------
    // position fields
    // ----------------------------------------------------------------------

    // 0..11
    typedef logic [3:0] re_idx_t;
    // 0..131
    typedef logic [8:0] prb_idx_t;
    // 0..13
    typedef logic [3:0] sym_idx_t;
    // free running, wraps at 256
    typedef logic [7:0] slot_idx_t;
    // group in high nibble, antenna in low nibble
    typedef logic [7:0] ant_info_t;

    // even pass sends antennas 0,2,4,6 and odd pass sends 1,3,5,7
    typedef enum logic
    {
        group_even = 1'b0,
        group_odd  = 1'b1
    } pos_state_t;

endpackage

/* source/re_stage_if.sv */
`timescale 1ns/100ps

interface re_stage_if;

    // handshake
    logic                  valid;
    logic                  ready;

    // four antenna samples of one RE
    dl_re_pkg::re_word_t   data;

    // position of the word in the grid
    dl_re_pkg::re_idx_t    re_idx;
    dl_re_pkg::prb_idx_t   prb_idx;
    dl_re_pkg::sym_idx_t   sym_idx;
    dl_re_pkg::slot_idx_t  slot_idx;
    // antenna group of the current pass
    logic                  group;

    // upstream side, drives valid and payload
    modport src
    (
        output valid,
        output data,
        output re_idx,
        output prb_idx,
        output sym_idx,
        output slot_idx,
        output group,
        input  ready
    );

    // downstream side, only drives ready
    modport dst
    (
        input  valid,
        input  data,
        input  re_idx,
        input  prb_idx,
        input  sym_idx,
        input  slot_idx,
        input  group,
        output ready
    );

endinterface

/* source/re_ingress.sv */
`timescale 1ns/100ps

module re_ingress
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_valid,
    output logic                 o_ready,
    input  dl_re_pkg::re_word_t  i_data,
    re_stage_if.src              m_out
);

    // output entry and skid entry
    logic                 out_valid;
    logic                 skid_valid;
    logic                 ready_q;
    dl_re_pkg::re_word_t  out_data;
    dl_re_pkg::re_word_t  skid_data;

    logic                 in_fire;
    logic                 out_fire;
    logic                 out_valid_nxt;
    logic                 skid_valid_nxt;
    logic                 load_from_skid;
    logic                 load_from_in;
    logic                 load_skid;

    // ----------------------------------------------------------------------
    // entry control
    // ----------------------------------------------------------------------

    assign in_fire  = i_valid & ready_q;
    assign out_fire = out_valid & m_out.ready;

    always_comb
    begin
        out_valid_nxt  = out_valid;
        skid_valid_nxt = skid_valid;
        load_from_skid = 1'b0;
        load_from_in   = 1'b0;
        load_skid      = 1'b0;
        if (!out_valid || out_fire)
        begin
            // skid entry is older, it drains first
            if (skid_valid)
            begin
                out_valid_nxt  = 1'b1;
                skid_valid_nxt = 1'b0;
                load_from_skid = 1'b1;
            end
            else
            begin
                out_valid_nxt = in_fire;
                load_from_in  = in_fire;
            end
        end
        else if (in_fire)
        begin
            // output held, park the word
            skid_valid_nxt = 1'b1;
            load_skid      = 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b1;
        end
        else
        begin
            out_valid  <= out_valid_nxt;
            skid_valid <= skid_valid_nxt;
            // drops only with both entries full
            ready_q    <= ~skid_valid_nxt;
        end
    end

    // payload
    always_ff @(posedge i_clk)
    begin
        if (load_from_skid)
            out_data <= skid_data;
        else if (load_from_in)
            out_data <= i_data;
        if (load_skid)
            skid_data <= i_data;
    end

    // ----------------------------------------------------------------------
    // outputs
    // ----------------------------------------------------------------------

    assign o_ready        = ready_q;
    assign m_out.valid    = out_valid;
    assign m_out.data     = out_data;
    // position unknown here, stamped by the next stage
    assign m_out.re_idx   = '0;
    assign m_out.prb_idx  = '0;
    assign m_out.sym_idx  = '0;
    assign m_out.slot_idx = '0;
    assign m_out.group    = 1'b0;

endmodule

/* source/re_position_counter.sv */
`timescale 1ns/100ps

module re_position_counter
(
    input  logic      i_clk,
    input  logic      i_rst,
    re_stage_if.dst   s_in,
    re_stage_if.src   m_out
);

    // last index values of each counter
    localparam dl_re_pkg::re_idx_t  RE_LAST  = dl_re_pkg::re_idx_t'(dl_re_pkg::RE_PER_PRB - 1);
    localparam dl_re_pkg::prb_idx_t PRB_LAST = dl_re_pkg::prb_idx_t'(dl_re_pkg::PRB_PER_SYM - 1);
    localparam dl_re_pkg::sym_idx_t SYM_LAST = dl_re_pkg::sym_idx_t'(dl_re_pkg::SYM_PER_SLOT - 1);

    logic                  out_valid;
    dl_re_pkg::re_word_t   out_data;

    // position of the word held in the output register
    dl_re_pkg::re_idx_t    re_cnt;
    dl_re_pkg::prb_idx_t   prb_cnt;
    dl_re_pkg::sym_idx_t   sym_cnt;
    dl_re_pkg::slot_idx_t  slot_cnt;
    dl_re_pkg::pos_state_t pos_state;

    logic                  out_fire;
    logic                  re_wrap;
    logic                  pass_end;

    // ----------------------------------------------------------------------
    // data register
    // ----------------------------------------------------------------------

    assign s_in.ready = ~out_valid | m_out.ready;
    assign out_fire   = out_valid & m_out.ready;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            out_valid <= 1'b0;
        else if (s_in.ready)
            out_valid <= s_in.valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (s_in.valid && s_in.ready)
            out_data <= s_in.data;
    end

    // ----------------------------------------------------------------------
    // position counters
    // ----------------------------------------------------------------------

    // move to the next word's position once the current one leaves
    assign re_wrap  = (re_cnt == RE_LAST);
    assign pass_end = re_wrap & (prb_cnt == PRB_LAST);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            re_cnt    <= '0;
            prb_cnt   <= '0;
            sym_cnt   <= '0;
            slot_cnt  <= '0;
            pos_state <= dl_re_pkg::group_even;
        end
        else if (out_fire)
        begin
            re_cnt <= re_wrap ? '0 : re_cnt + 1'b1;
            if (re_wrap)
                prb_cnt <= pass_end ? '0 : prb_cnt + 1'b1;
            if (pass_end)
            begin
                case (pos_state)
                    dl_re_pkg::group_even:
                    begin
                        // same symbol again for the odd antennas
                        pos_state <= dl_re_pkg::group_odd;
                    end
                    default:
                    begin
                        // both groups sent, next symbol
                        pos_state <= dl_re_pkg::group_even;
                        sym_cnt   <= (sym_cnt == SYM_LAST) ? '0 : sym_cnt + 1'b1;
                        if (sym_cnt == SYM_LAST)
                            slot_cnt <= slot_cnt + 1'b1;
                    end
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // outputs
    // ----------------------------------------------------------------------

    assign m_out.valid    = out_valid;
    assign m_out.data     = out_data;
    assign m_out.re_idx   = re_cnt;
    assign m_out.prb_idx  = prb_cnt;
    assign m_out.sym_idx  = sym_cnt;
    assign m_out.slot_idx = slot_cnt;
    assign m_out.group    = (pos_state == dl_re_pkg::group_odd);

endmodule

/* source/re_packet_tagger.sv */
`timescale 1ns/100ps

module re_packet_tagger
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    re_stage_if.dst               s_in,
    input  logic                  i_ready,
    output logic                  o_valid,
    output dl_re_pkg::iq_sample_t o_lane0_data,
    output dl_re_pkg::iq_sample_t o_lane1_data,
    output dl_re_pkg::iq_sample_t o_lane2_data,
    output dl_re_pkg::iq_sample_t o_lane3_data,
    output dl_re_pkg::ant_info_t  o_lane0_info,
    output dl_re_pkg::ant_info_t  o_lane1_info,
    output dl_re_pkg::ant_info_t  o_lane2_info,
    output dl_re_pkg::ant_info_t  o_lane3_info,
    output logic                  o_sop,
    output logic                  o_eop,
    output dl_re_pkg::prb_idx_t   o_prb_idx,
    output dl_re_pkg::sym_idx_t   o_sym_idx,
    output dl_re_pkg::slot_idx_t  o_slot_idx
);

    // PRB position inside a packet
    localparam int unsigned PKT_POS_W = $clog2(dl_re_pkg::PRB_PER_PKT);

    dl_re_pkg::iq_sample_t lane_data [dl_re_pkg::LANE_NUM];
    dl_re_pkg::ant_info_t  lane_info [dl_re_pkg::LANE_NUM];

    logic                  load;
    logic                  first_re;
    logic                  last_re;
    logic [PKT_POS_W-1:0]  pkt_pos;

    assign s_in.ready = ~o_valid | i_ready;
    assign load       = s_in.valid & s_in.ready;

    // ----------------------------------------------------------------------
    // packet boundaries
    // ----------------------------------------------------------------------

    assign pkt_pos  = s_in.prb_idx[PKT_POS_W-1:0];
    assign first_re = (s_in.re_idx == '0) && (pkt_pos == '0);
    // last RE of the fourth PRB
    assign last_re  = (s_in.re_idx == dl_re_pkg::re_idx_t'(dl_re_pkg::RE_PER_PRB - 1))
                      && (pkt_pos == PKT_POS_W'(dl_re_pkg::PRB_PER_PKT - 1));

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_valid    <= 1'b0;
            o_sop      <= 1'b0;
            o_eop      <= 1'b0;
            o_prb_idx  <= '0;
            o_sym_idx  <= '0;
            o_slot_idx <= '0;
        end
        else if (s_in.ready)
        begin
            o_valid <= s_in.valid;
            // marks only live with a valid word
            o_sop   <= s_in.valid & first_re;
            o_eop   <= s_in.valid & last_re;
            if (s_in.valid)
            begin
                o_prb_idx  <= s_in.prb_idx;
                o_sym_idx  <= s_in.sym_idx;
                o_slot_idx <= s_in.slot_idx;
            end
        end
    end

    // ----------------------------------------------------------------------
    // lane split and info tags
    // ----------------------------------------------------------------------

    for (genvar k = 0; k < dl_re_pkg::LANE_NUM; k++)
    begin : g_lane
        always_ff @(posedge i_clk)
        begin
            if (load)
            begin
                lane_data[k] <= s_in.data[k*dl_re_pkg::IQ_W +: dl_re_pkg::IQ_W];
                // antenna 2k+group is just {k, group}
                lane_info[k] <= {3'b000, s_in.group, 3'(k), s_in.group};
            end
        end
    end

    assign o_lane0_data = lane_data[0];
    assign o_lane1_data = lane_data[1];
    assign o_lane2_data = lane_data[2];
    assign o_lane3_data = lane_data[3];
    assign o_lane0_info = lane_info[0];
    assign o_lane1_info = lane_info[1];
    assign o_lane2_info = lane_info[2];
    assign o_lane3_info = lane_info[3];

endmodule

/* source/dl_re_framer.sv */
`timescale 1ns/100ps

module dl_re_framer
(
    input  logic                  sys_clk_368_64,
    input  logic                  sys_rst_491_52,

    // input RE stream
    input  logic                  i_re_valid,
    output logic                  o_re_ready,
    input  dl_re_pkg::re_word_t   i_re_data,

    // framed lane output
    input  logic                  i_lane_ready,
    output logic                  o_lane_valid,
    output dl_re_pkg::iq_sample_t o_lane0_data,
    output dl_re_pkg::iq_sample_t o_lane1_data,
    output dl_re_pkg::iq_sample_t o_lane2_data,
    output dl_re_pkg::iq_sample_t o_lane3_data,
    output dl_re_pkg::ant_info_t  o_lane0_info,
    output dl_re_pkg::ant_info_t  o_lane1_info,
    output dl_re_pkg::ant_info_t  o_lane2_info,
    output dl_re_pkg::ant_info_t  o_lane3_info,
    output logic                  o_sop,
    output logic                  o_eop,
    output dl_re_pkg::prb_idx_t   o_prb_idx,
    output dl_re_pkg::sym_idx_t   o_sym_idx,
    output dl_re_pkg::slot_idx_t  o_slot_idx
);

    // ----------------------------------------------------------------------
    // stage links
    // ----------------------------------------------------------------------

    // skid buffer to position counter
    re_stage_if ing_to_pos ();
    // position counter to tagger
    re_stage_if pos_to_tag ();

    // two entries, registered ready toward the source
    re_ingress u_ingress
    (
        .i_clk   (sys_clk_368_64),
        .i_rst   (sys_rst_491_52),
        .i_valid (i_re_valid),
        .o_ready (o_re_ready),
        .i_data  (i_re_data),
        .m_out   (ing_to_pos)
    );

    // stamps RE, PRB, symbol, slot and group
    re_position_counter u_position
    (
        .i_clk (sys_clk_368_64),
        .i_rst (sys_rst_491_52),
        .s_in  (ing_to_pos),
        .m_out (pos_to_tag)
    );

    // packet marks, lanes and info tags
    re_packet_tagger u_tagger
    (
        .i_clk        (sys_clk_368_64),
        .i_rst        (sys_rst_491_52),
        .s_in         (pos_to_tag),
        .i_ready      (i_lane_ready),
        .o_valid      (o_lane_valid),
        .o_lane0_data (o_lane0_data),
        .o_lane1_data (o_lane1_data),
        .o_lane2_data (o_lane2_data),
        .o_lane3_data (o_lane3_data),
        .o_lane0_info (o_lane0_info),
        .o_lane1_info (o_lane1_info),
        .o_lane2_info (o_lane2_info),
        .o_lane3_info (o_lane3_info),
        .o_sop        (o_sop),
        .o_eop        (o_eop),
        .o_prb_idx    (o_prb_idx),
        .o_sym_idx    (o_sym_idx),
        .o_slot_idx   (o_slot_idx)
    );

endmodule

/* dv/dl_re_framer_chk.sv */
`timescale 1ns/100ps

module dl_re_framer_chk
(
    input  logic                  sys_clk_368_64,
    input  logic                  sys_rst_491_52,
    input  logic                  i_re_valid,
    input  logic                  o_re_ready,
    input  logic                  i_lane_ready,
    input  logic                  o_lane_valid,
    input  dl_re_pkg::iq_sample_t o_lane0_data,
    input  dl_re_pkg::iq_sample_t o_lane1_data,
    input  dl_re_pkg::iq_sample_t o_lane2_data,
    input  dl_re_pkg::iq_sample_t o_lane3_data,
    input  dl_re_pkg::ant_info_t  o_lane0_info,
    input  dl_re_pkg::ant_info_t  o_lane1_info,
    input  dl_re_pkg::ant_info_t  o_lane2_info,
    input  dl_re_pkg::ant_info_t  o_lane3_info,
    input  logic                  o_sop,
    input  logic                  o_eop,
    input  dl_re_pkg::prb_idx_t   o_prb_idx,
    input  dl_re_pkg::sym_idx_t   o_sym_idx,
    input  dl_re_pkg::slot_idx_t  o_slot_idx
);

    // ----------------------------------------------------------------------
    // handshake hold rules
    // ----------------------------------------------------------------------

    // stalled output word keeps its payload and marks
    a_out_hold : assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        o_lane_valid && !i_lane_ready |=> o_lane_valid
        && $stable({o_lane3_data, o_lane2_data, o_lane1_data, o_lane0_data})
        && $stable({o_lane3_info, o_lane2_info, o_lane1_info, o_lane0_info})
        && $stable({o_sop, o_eop, o_prb_idx, o_sym_idx, o_slot_idx}))
        else $error("lane output changed while stalled");

    // ingress ready drops only after it took a word
    a_in_ready : assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        o_re_ready && !i_re_valid |=> o_re_ready)
        else $error("input ready dropped with no word taken");

    // ----------------------------------------------------------------------
    // marks and reset
    // ----------------------------------------------------------------------

    // start and end of a 48-word packet never share a word
    a_mark_excl : assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        !(o_sop && o_eop))
        else $error("sop and eop high together");

    a_reset_quiet : assert property (@(posedge sys_clk_368_64)
        sys_rst_491_52 |=> !o_lane_valid && !o_sop && !o_eop)
        else $error("output active during reset");

endmodule

bind dl_re_framer dl_re_framer_chk u_chk
(
    .sys_clk_368_64 (sys_clk_368_64),
    .sys_rst_491_52 (sys_rst_491_52),
    .i_re_valid     (i_re_valid),
    .o_re_ready     (o_re_ready),
    .i_lane_ready   (i_lane_ready),
    .o_lane_valid   (o_lane_valid),
    .o_lane0_data   (o_lane0_data),
    .o_lane1_data   (o_lane1_data),
    .o_lane2_data   (o_lane2_data),
    .o_lane3_data   (o_lane3_data),
    .o_lane0_info   (o_lane0_info),
    .o_lane1_info   (o_lane1_info),
    .o_lane2_info   (o_lane2_info),
    .o_lane3_info   (o_lane3_info),
    .o_sop          (o_sop),
    .o_eop          (o_eop),
    .o_prb_idx      (o_prb_idx),
    .o_sym_idx      (o_sym_idx),
    .o_slot_idx     (o_slot_idx)
);

/* dv/tb_dl_re_framer.sv */
`timescale 1ns/100ps

module tb_dl_re_framer;

    // 132 PRBs of 12 REs
    localparam int WORDS_PER_PASS = 1584;
    // cycles without any output word before giving up
    localparam int IDLE_LIMIT     = 500;

    logic                  sys_clk_368_64 = 1'b0;
    logic                  sys_rst_491_52 = 1'b1;
    logic                  i_re_valid     = 1'b0;
    dl_re_pkg::re_word_t   i_re_data      = '0;
    logic                  i_lane_ready   = 1'b1;
    logic                  o_re_ready;
    logic                  o_lane_valid;
    dl_re_pkg::iq_sample_t lane_data [4];
    dl_re_pkg::ant_info_t  lane_info [4];
    logic                  o_sop;
    logic                  o_eop;
    dl_re_pkg::prb_idx_t   o_prb_idx;
    dl_re_pkg::sym_idx_t   o_sym_idx;
    dl_re_pkg::slot_idx_t  o_slot_idx;

    // accepted words and their accept cycle for the scoreboard
    dl_re_pkg::re_word_t   word_q [$];
    int                    accept_q [$];
    int                    cycle_cnt     = 0;
    int                    out_count     = 0;
    logic                  no_stall_yet  = 1'b1;
    logic [31:0]           lfsr_state    = 32'hc5c6;
    int                    gap_density   = 0;
    int                    stall_density = 0;

    // current checkpoint is armed while done_seq lags seq
    int                    ckpt_seq      = 0;
    int                    ckpt_done_seq = 0;
    int                    ckpt_n;
    int                    ckpt_prb;
    int                    ckpt_sym;
    int                    ckpt_slot;
    int                    ckpt_grp;
    int                    ckpt_sop;
    int                    ckpt_eop;

    dl_re_framer UUT
    (
        .sys_clk_368_64 (sys_clk_368_64),
        .sys_rst_491_52 (sys_rst_491_52),
        .i_re_valid     (i_re_valid),
        .o_re_ready     (o_re_ready),
        .i_re_data      (i_re_data),
        .i_lane_ready   (i_lane_ready),
        .o_lane_valid   (o_lane_valid),
        .o_lane0_data   (lane_data[0]),
        .o_lane1_data   (lane_data[1]),
        .o_lane2_data   (lane_data[2]),
        .o_lane3_data   (lane_data[3]),
        .o_lane0_info   (lane_info[0]),
        .o_lane1_info   (lane_info[1]),
        .o_lane2_info   (lane_info[2]),
        .o_lane3_info   (lane_info[3]),
        .o_sop          (o_sop),
        .o_eop          (o_eop),
        .o_prb_idx      (o_prb_idx),
        .o_sym_idx      (o_sym_idx),
        .o_slot_idx     (o_slot_idx)
    );

    initial
    begin
        forever #4 sys_clk_368_64 = ~sys_clk_368_64;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [127:0] next_bits(input int width);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < width; i++)
        begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // ----------------------------------------------------------------------
    // output scoreboard
    // ----------------------------------------------------------------------

    task automatic compare_output_word;
        dl_re_pkg::re_word_t exp_word;
        int                  acc;
        int                  grp;
        if (word_q.size() == 0)
            stop_with_failure($sformatf("output word %0d came with no input word queued",
                                        out_count));
        else
        begin
            exp_word = word_q.pop_front();
            acc      = accept_q.pop_front();
            // even pass carries group 0 and odd pass group 1
            grp      = (out_count / WORDS_PER_PASS) % 2;
            for (int k = 0; k < 4; k++)
            begin
                check_value($sformatf("o_lane%0d_data", k), 128'(lane_data[k]),
                            128'(exp_word[32*k +: 32]));
                check_value($sformatf("o_lane%0d_info", k), 128'(lane_info[k]),
                            128'({4'(grp), 4'(2*k + grp)}));
            end
            // fixed latency only holds with ready never dropped
            if (no_stall_yet)
                check_value("accept_to_output_cycles", 128'(cycle_cnt - acc), 128'(3));
            if (ckpt_done_seq != ckpt_seq && out_count == ckpt_n)
            begin
                check_value("o_prb_idx", 128'(o_prb_idx), 128'(ckpt_prb));
                check_value("o_sym_idx", 128'(o_sym_idx), 128'(ckpt_sym));
                check_value("o_slot_idx", 128'(o_slot_idx), 128'(ckpt_slot));
                check_value("o_lane0_info group", 128'(lane_info[0][7:4]), 128'(ckpt_grp));
                check_value("o_sop", 128'(o_sop), 128'(ckpt_sop));
                check_value("o_eop", 128'(o_eop), 128'(ckpt_eop));
                ckpt_done_seq = ckpt_seq;
            end
            out_count = out_count + 1;
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus and output sampling on pre-edge values
    // ----------------------------------------------------------------------

    always @(posedge sys_clk_368_64)
    begin
        logic [127:0] bits;
        cycle_cnt = cycle_cnt + 1;
        if (!sys_rst_491_52)
        begin
            if (o_lane_valid && i_lane_ready)
                compare_output_word();
            if (i_re_valid && o_re_ready)
            begin
                word_q.push_back(i_re_data);
                accept_q.push_back(cycle_cnt);
            end
            // new word or gap only once the last one is taken
            if (!i_re_valid || o_re_ready)
            begin
                bits = next_bits(2);
                if (int'(bits[1:0]) < gap_density)
                    i_re_valid <= 1'b0;
                else
                begin
                    i_re_valid <= 1'b1;
                    i_re_data  <= next_bits(128);
                end
            end
            bits = next_bits(2);
            if (int'(bits[1:0]) < stall_density)
            begin
                i_lane_ready <= 1'b0;
                no_stall_yet = 1'b0;
            end
            else
                i_lane_ready <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // reset, trace checkpoints, end of run
    // ----------------------------------------------------------------------

    initial
    begin
        int    fd;
        int    fields;
        int    ckpt_total;
        int    idle;
        int    last_count;
        int    n;
        int    prb;
        int    sym;
        int    slot;
        int    grp;
        int    sop;
        int    eop;
        int    gap;
        int    stall;
        string line;
        ckpt_total = 0;
        repeat (16) @(posedge sys_clk_368_64);
        sys_rst_491_52 <= 1'b0;
        @(negedge sys_clk_368_64);
        // quiet outputs straight after reset
        check_value("o_lane_valid", 128'(o_lane_valid), 128'(0));
        check_value("o_sop", 128'(o_sop), 128'(0));
        check_value("o_eop", 128'(o_eop), 128'(0));
        check_value("o_re_ready", 128'(o_re_ready), 128'(1));
        fd = $fopen("dv/dl_re_trace.txt", "r");
        if (fd == 0)
            stop_with_failure("cannot open trace file dv/dl_re_trace.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line   = "";
                fields = $fgets(line, fd);
                if (fields > 0 && line.len() > 1 && line.getc(0) != "#")
                begin
                    fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                                     n, prb, sym, slot, grp, sop, eop, gap, stall);
                    if (fields != 9)
                        stop_with_failure($sformatf("malformed trace line: %s", line));
                    if (out_count > n)
                        stop_with_failure($sformatf("trace word %0d is already past", n));
                    ckpt_n        = n;
                    ckpt_prb      = prb;
                    ckpt_sym      = sym;
                    ckpt_slot     = slot;
                    ckpt_grp      = grp;
                    ckpt_sop      = sop;
                    ckpt_eop      = eop;
                    gap_density   = gap;
                    stall_density = stall;
                    ckpt_seq      = ckpt_seq + 1;
                    idle          = 0;
                    last_count    = out_count;
                    while (ckpt_done_seq != ckpt_seq)
                    begin
                        @(negedge sys_clk_368_64);
                        if (out_count != last_count)
                        begin
                            last_count = out_count;
                            idle       = 0;
                        end
                        else
                            idle = idle + 1;
                        if (idle > IDLE_LIMIT)
                            stop_with_failure($sformatf(
                                "no output for %0d cycles while waiting for word %0d",
                                IDLE_LIMIT, n));
                    end
                    ckpt_total = ckpt_total + 1;
                end
            end
            $fclose(fd);
            if (ckpt_total > 0)
            begin
                $display("checked %0d checkpoints over %0d words", ckpt_total, out_count);
                $display("STATUS: PASS");
                $finish;
            end
            else
                stop_with_failure("trace file holds no checkpoints");
        end
    end

endmodule

/* src.f */
source/dl_re_pkg.sv
source/re_stage_if.sv
source/re_ingress.sv
source/re_position_counter.sv
source/re_packet_tagger.sv
source/dl_re_framer.sv
dv/dl_re_framer_chk.sv
dv/tb_dl_re_framer.sv

/* run_sim.sh */
#!/bin/sh
# build the framer testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_dl_re_framer \
    -f src.f \
    -o tb_dl_re_framer > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dl_re_framer > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "^STATUS: PASS$" "$SIM_LOG"; then
    if [ $sim_status -ne 0 ]; then
        echo "simulator exited with status $sim_status"
        exit 1
    fi
    exit 0
fi

echo "simulation did not pass"
exit 1

/* dv/dl_re_trace.txt */
# word prb sym slot group sop eop gap stall
# gap and stall are chances in quarters (0..3) per cycle, used until that word leaves
0 0 0 0 0 1 0 0 0
11 0 0 0 0 0 0 1 0
12 1 0 0 0 0 0 2 0
47 3 0 0 0 0 1 0 0
48 4 0 0 0 1 0 1 0
95 7 0 0 0 0 1 3 0
1000 83 0 0 0 0 0 0 3
1583 131 0 0 0 0 1 1 1
1584 0 0 0 1 1 0 1 1
2000 34 0 0 1 0 0 2 2
3167 131 0 0 1 0 1 0 1
3168 0 1 0 0 1 0 0 0
4752 0 1 0 1 1 0 1 2
6336 0 2 0 0 1 0 1 1
7000 55 2 0 0 0 0 3 3
10000 41 3 0 0 0 0 0 2
12672 0 4 0 0 1 0 1 0
15000 62 4 0 1 0 0 1 1
20000 82 6 0 0 0 0 0 0
22175 131 6 0 1 0 1 2 1
22176 0 7 0 0 1 0 1 1
30000 124 9 0 0 1 0 0 1
41183 131 12 0 1 0 1 1 1
41184 0 13 0 0 1 0 1 2
42768 0 13 0 1 1 0 0 1
44351 131 13 0 1 0 1 1 1
44352 0 0 1 0 1 0 1 1
45935 131 0 1 0 0 1 0 2
45936 0 0 1 1 1 0 1 0
47520 0 1 1 0 1 0 1 1
48000 40 1 1 0 1 0 2 1
48011 40 1 1 0 0 0 0 0
